// File: decodeStage.sv
module decodeStage (
    input  logic          clk,
    input  logic          rstN,
    input  logic          ifIdValid,
    input  procPkg::ifIdT ifIdData,
    regWriteIf.sink       wr,
    output procPkg::idExT idExData,
    output logic          stopFetch,
    output logic          err
);
    import procPkg::*;

    logic [dataW-1:0] regs [numRegs];

    opcodeT op;
    logic [regAddrW-1:0] rd;
    logic [regAddrW-1:0] rs;
    logic [regAddrW-1:0] rt;
    logic [dataW-1:0] imm6Ext;
    logic [dataW-1:0] imm9Ext;
    logic [dataW-1:0] imm12Ext;
    logic illegal;

    // Write-through so a same-cycle write is seen
    function automatic logic [dataW-1:0] readReg(input logic [regAddrW-1:0] r);
        if (wr.en && wr.addr == r) begin
            return wr.data;
        end
        return regs[r];
    endfunction

    always_ff @(posedge clk) begin
        if (wr.en) begin
            regs[wr.addr] <= wr.data;
        end
    end

    // Instruction fields
    assign op = opcodeT'(ifIdData.instr[15:12]);
    assign rd = ifIdData.instr[11:9];
    assign rs = ifIdData.instr[8:6];
    assign rt = ifIdData.instr[5:3];

    assign imm6Ext = {{(dataW-6){ifIdData.instr[5]}}, ifIdData.instr[5:0]};
    assign imm9Ext = {{(dataW-9){ifIdData.instr[8]}}, ifIdData.instr[8:0]};
    assign imm12Ext = {{(dataW-12){ifIdData.instr[11]}}, ifIdData.instr[11:0]};

    always_comb begin
        idExData = '0;
        idExData.op = op;
        idExData.pc = ifIdData.pc;
        idExData.dest = rd;
        idExData.rsVal = readReg(rs);
        // Stores carry rd as the data operand
        idExData.rtVal = (op == opSt) ? readReg(rd) : readReg(rt);
        illegal = 1'b0;

        case (op)
            opAdd, opSub, opAnd, opXor: begin
                idExData.regWrite = 1'b1;
            end
            opAddi: begin
                idExData.regWrite = 1'b1;
                idExData.imm = imm6Ext;
            end
            opLi: begin
                idExData.regWrite = 1'b1;
                idExData.imm = imm9Ext;
            end
            opLd: begin
                idExData.regWrite = 1'b1;
                idExData.memRead = 1'b1;
                idExData.imm = imm6Ext;
            end
            opSt: begin
                idExData.memWrite = 1'b1;
                idExData.imm = imm6Ext;
            end
            opBeqz, opBnez: begin
                idExData.imm = imm6Ext;
            end
            opJ: begin
                idExData.imm = imm12Ext;
            end
            opNop: begin
                idExData.imm = '0;
            end
            opHalt: begin
                idExData.halt = 1'b1;
            end
            default: begin
                // Undefined op stops the core like a halt
                illegal = 1'b1;
                idExData.halt = 1'b1;
            end
        endcase
    end

    assign stopFetch = ifIdValid && idExData.halt;

    // Sticky once raised
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            err <= 1'b0;
        end else if (ifIdValid && illegal) begin
            err <= 1'b1;
        end
    end

endmodule

// File: executeStage.sv
module executeStage (
    input  logic                      idExValid,
    input  procPkg::idExT             idExData,
    output procPkg::exMemT            exMemData,
    output logic                      redirect,
    output logic [procPkg::dataW-1:0] target
);
    import procPkg::*;

    logic [dataW-1:0] aluOut;
    logic taken;

    always_comb begin
        case (idExData.op)
            opAdd: aluOut = idExData.rsVal + idExData.rtVal;
            opSub: aluOut = idExData.rsVal - idExData.rtVal;
            opAnd: aluOut = idExData.rsVal & idExData.rtVal;
            opXor: aluOut = idExData.rsVal ^ idExData.rtVal;
            // Immediate add doubles as address generation
            opAddi, opLd, opSt: aluOut = idExData.rsVal + idExData.imm;
            opLi: aluOut = idExData.imm;
            default: aluOut = '0;
        endcase
    end

    // Branch condition tests rs only
    always_comb begin
        case (idExData.op)
            opBeqz: taken = (idExData.rsVal == '0);
            opBnez: taken = (idExData.rsVal != '0);
            opJ: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign redirect = idExValid && taken;

    // Offset is relative to the next word
    assign target = idExData.pc + 1'b1 + idExData.imm;

    always_comb begin
        exMemData.result = aluOut;
        exMemData.storeData = idExData.rtVal;
        exMemData.dest = idExData.dest;
        exMemData.regWrite = idExData.regWrite;
        exMemData.memRead = idExData.memRead;
        exMemData.memWrite = idExData.memWrite;
        exMemData.halt = idExData.halt;
        exMemData.pc = idExData.pc;
    end

endmodule

// File: fetchStage.sv
module fetchStage (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic                      stall,
    input  logic                      redirect,
    input  logic [procPkg::dataW-1:0] target,
    input  logic                      stopFetch,
    output logic [procPkg::dataW-1:0] instrAddr,
    output logic                      fetchValid,
    output logic                      holdIfId,
    output logic                      flushIfId,
    output logic                      flushIdEx
);
    import procPkg::*;

    logic [dataW-1:0] pc;
    // Set once a halt or illegal op passes decode
    logic stopped;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
            stopped <= 1'b0;
        end else begin
            if (stopFetch && !redirect) begin
                stopped <= 1'b1;
            end
            if (redirect) begin
                pc <= target;
            end else if (!(stall || stopFetch || stopped)) begin
                pc <= pc + 1'b1;
            end
        end
    end

    assign instrAddr = pc;

    // Word behind a halt enters IF/ID as a bubble
    assign fetchValid = !(stopFetch || stopped);

    // Redirect wins and releases the stall
    assign holdIfId = stall && !redirect;
    assign flushIfId = redirect;

    // A stall lets a bubble into execute
    assign flushIdEx = redirect || stall;

endmodule

// File: memWbStage.sv
module memWbStage (
    input  logic           clk,
    input  logic           rstN,
    input  logic           exMemValid,
    input  procPkg::exMemT exMemData,
    regWriteIf.source      wr,
    output logic           halted
);
    import procPkg::*;

    logic [dataW-1:0] dmem [dmemWords];
    logic [dmemAddrW-1:0] addr;
    logic [dataW-1:0] loadData;

    // Upper address bits ignored
    assign addr = exMemData.result[dmemAddrW-1:0];

    always_ff @(posedge clk) begin
        if (exMemValid && exMemData.memWrite) begin
            dmem[addr] <= exMemData.storeData;
        end
    end

    // Asynchronous read so loads finish in this stage
    assign loadData = dmem[addr];

    assign wr.en = exMemValid && exMemData.regWrite;
    assign wr.addr = exMemData.dest;
    assign wr.data = exMemData.memRead ? loadData : exMemData.result;
    assign wr.pc = exMemData.pc;

    // Nothing valid follows a halt
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            halted <= 1'b0;
        end else if (exMemValid && exMemData.halt) begin
            halted <= 1'b1;
        end
    end

endmodule

// File: pipeReg.sv
module pipeReg #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    rstN,
    input  logic    hold,
    input  logic    flush,
    input  logic    inValid,
    input  payloadT inData,
    output logic    outValid,
    output payloadT outData
);

    // Flush beats hold, so a held stage can still be squashed
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            outValid <= 1'b0;
        end else if (flush) begin
            outValid <= 1'b0;
        end else if (!hold) begin
            outValid <= inValid;
        end
    end

    // Payload only matters while valid is set
    always_ff @(posedge clk) begin
        if (!hold) begin
            outData <= inData;
        end
    end

endmodule

// File: proc.sv
module proc (
    input  logic                         clk,
    input  logic                         rstN,
    output logic [procPkg::dataW-1:0]    instrAddr,
    input  logic [procPkg::dataW-1:0]    instrData,
    output logic                         wbEn,
    output logic [procPkg::regAddrW-1:0] wbReg,
    output logic [procPkg::dataW-1:0]    wbData,
    output logic [procPkg::dataW-1:0]    wbPc,
    output logic                         halted,
    output logic                         err
);
    import procPkg::*;

    logic stall, redirect, stopFetch, fetchValid;
    logic holdIfId, flushIfId, flushIdEx;
    logic [dataW-1:0] target;

    logic ifIdValid, idExValid, exMemValid;
    ifIdT ifIdIn, ifIdData;
    idExT idExIn, idExData;
    exMemT exMemIn, exMemData;

    regWriteIf wr ();

    fetchStage fetch (
        .clk(clk), .rstN(rstN), .stall(stall), .redirect(redirect), .target(target),
        .stopFetch(stopFetch), .instrAddr(instrAddr), .fetchValid(fetchValid),
        .holdIfId(holdIfId), .flushIfId(flushIfId), .flushIdEx(flushIdEx)
    );

    assign ifIdIn = '{instr: instrData, pc: instrAddr};

    pipeReg #(.payloadT(ifIdT)) ifIdReg (
        .clk(clk), .rstN(rstN), .hold(holdIfId), .flush(flushIfId),
        .inValid(fetchValid), .inData(ifIdIn), .outValid(ifIdValid), .outData(ifIdData)
    );

    stallUnit stallCheck (
        .ifIdValid(ifIdValid), .ifIdData(ifIdData), .idExValid(idExValid),
        .idExData(idExData), .exMemValid(exMemValid), .exMemData(exMemData), .stall(stall)
    );

    decodeStage decode (
        .clk(clk), .rstN(rstN), .ifIdValid(ifIdValid), .ifIdData(ifIdData), .wr(wr.sink),
        .idExData(idExIn), .stopFetch(stopFetch), .err(err)
    );

    pipeReg #(.payloadT(idExT)) idExReg (
        .clk(clk), .rstN(rstN), .hold(1'b0), .flush(flushIdEx),
        .inValid(ifIdValid), .inData(idExIn), .outValid(idExValid), .outData(idExData)
    );

    executeStage execute (
        .idExValid(idExValid), .idExData(idExData), .exMemData(exMemIn),
        .redirect(redirect), .target(target)
    );

    pipeReg #(.payloadT(exMemT)) exMemReg (
        .clk(clk), .rstN(rstN), .hold(1'b0), .flush(1'b0),
        .inValid(idExValid), .inData(exMemIn), .outValid(exMemValid), .outData(exMemData)
    );

    memWbStage memWb (
        .clk(clk), .rstN(rstN), .exMemValid(exMemValid), .exMemData(exMemData),
        .wr(wr.source), .halted(halted)
    );

    // Register writes exposed for observation
    assign wbEn = wr.en;
    assign wbReg = wr.addr;
    assign wbData = wr.data;
    assign wbPc = wr.pc;

endmodule

// File: procChecker.sv
module procChecker (
    input logic                         clk,
    input logic                         rstN,
    input logic                         wbEn,
    input logic [procPkg::regAddrW-1:0] wbReg,
    input logic [procPkg::dataW-1:0]    wbData,
    input logic [procPkg::dataW-1:0]    wbPc,
    input logic                         halted,
    input logic                         err
);
    import procPkg::*;

    // Expected register writes in program order
    logic [regAddrW-1:0] expReg [256];
    logic [dataW-1:0] expData [256];
    int expCount = 0;
    int nextIdx = 0;
    int writeCount = 0;
    int errorCount = 0;
    logic expErr = 1'b0;

    // Program words, used to confirm the reported PC
    logic [dataW-1:0] prog [256];
    int progWords = 0;

    task automatic addWrite(input logic [regAddrW-1:0] r, input logic [dataW-1:0] d);
        expReg[expCount] = r;
        expData[expCount] = d;
        expCount++;
    endtask

    task automatic addInstr(input logic [dataW-1:0] w);
        prog[progWords] = w;
        progWords++;
    endtask

    task automatic setExpectedErr(input logic e);
        expErr = e;
    endtask

    // True when the program word at pc writes register r
    function automatic logic pcWritesReg(input logic [dataW-1:0] pc,
                                         input logic [regAddrW-1:0] r);
        opcodeT op;
        if ($isunknown(pc) || pc >= progWords) begin
            return 1'b0;
        end
        op = opcodeT'(prog[pc][15:12]);
        return (op inside {opAdd, opSub, opAnd, opXor, opAddi, opLi, opLd}) &&
               (prog[pc][11:9] === r);
    endfunction

    // Write port settles after the rising edge
    always @(negedge clk) begin
        if (rstN && wbEn) begin
            writeCount++;
            if (halted) begin
                $display("ERROR at %0t: write to r%0d after the core halted", $time, wbReg);
                errorCount++;
            end
            if (nextIdx >= expCount) begin
                $display("ERROR at %0t: unexpected write r%0d = %h from pc %h",
                         $time, wbReg, wbData, wbPc);
                errorCount++;
            end else begin
                if (wbReg !== expReg[nextIdx]) begin
                    $display("MISMATCH at %0t: wbReg expected %0d actual %0d (pc %h)",
                             $time, expReg[nextIdx], wbReg, wbPc);
                    errorCount++;
                end
                if (wbData !== expData[nextIdx]) begin
                    $display("MISMATCH at %0t: wbData expected %h actual %h (pc %h)",
                             $time, expData[nextIdx], wbData, wbPc);
                    errorCount++;
                end
                nextIdx++;
            end
            if (!pcWritesReg(wbPc, wbReg)) begin
                $display("ERROR at %0t: write to r%0d reports pc %h, whose word does not write it",
                         $time, wbReg, wbPc);
                errorCount++;
            end
        end
    end

    // Run once the core has stopped
    task automatic checkEnd();
        if (err !== expErr) begin
            $display("MISMATCH at %0t: err expected %b actual %b", $time, expErr, err);
            errorCount++;
        end
        if (nextIdx < expCount) begin
            $display("ERROR at %0t: %0d expected register writes never happened",
                     $time, expCount - nextIdx);
            errorCount++;
        end
    endtask

endmodule

// File: procPkg.sv
package procPkg;

    localparam int dataW = 16;
    localparam int regAddrW = 3;
    localparam int numRegs = 8;
    localparam int dmemWords = 64;
    localparam int dmemAddrW = $clog2(dmemWords);

    // Codes 13 to 15 are undefined
    typedef enum logic [3:0] {
        opAdd  = 4'd0,
        opSub  = 4'd1,
        opAnd  = 4'd2,
        opXor  = 4'd3,
        opAddi = 4'd4,
        opLi   = 4'd5,
        opLd   = 4'd6,
        opSt   = 4'd7,
        opBeqz = 4'd8,
        opBnez = 4'd9,
        opJ    = 4'd10,
        opNop  = 4'd11,
        opHalt = 4'd12
    } opcodeT;

    typedef struct packed {
        logic [dataW-1:0] instr;
        logic [dataW-1:0] pc;
    } ifIdT;

    typedef struct packed {
        opcodeT op;
        logic [dataW-1:0] rsVal;
        // Holds the rd value for stores
        logic [dataW-1:0] rtVal;
        logic [dataW-1:0] imm;
        logic [regAddrW-1:0] dest;
        logic regWrite;
        logic memRead;
        logic memWrite;
        logic halt;
        logic [dataW-1:0] pc;
    } idExT;

    typedef struct packed {
        logic [dataW-1:0] result;
        logic [dataW-1:0] storeData;
        logic [regAddrW-1:0] dest;
        logic regWrite;
        logic memRead;
        logic memWrite;
        logic halt;
        logic [dataW-1:0] pc;
    } exMemT;

endpackage

// File: procTrace.txt
# I word: instruction word in hex, loaded from address 0 upward
# W reg data: expected register write in program order, E flag: expected err
I 5205  00 li   r1, 5
I 5403  01 li   r2, 3
I 0650  02 add  r3, r1, r2
I 18C8  03 sub  r4, r3, r1
I 2B08  04 and  r5, r4, r1
I 3D58  05 xor  r6, r5, r3
I 4FBE  06 addi r7, r6, -2
I 51FF  07 li   r0, -1
I 7E4A  08 st   r7, 10(r1)
I 644A  09 ld   r2, 10(r1)
I 0690  10 add  r3, r2, r2
I 8142  11 beqz r5, +2 not taken
I 9142  12 bnez r5, +2 taken to 15
I 5255  13 li   r1, 0x55 skipped
I 5466  14 li   r2, 0x66 skipped
I 5800  15 li   r4, 0
I 8101  16 beqz r4, +1 taken to 18
I 5A77  17 li   r5, 0x77 skipped
I 9103  18 bnez r4, +3 not taken
I A002  19 j    +2 to 22
I 5C11  20 li   r6, 0x11 skipped
I 5E22  21 li   r7, 0x22 skipped
I B000  22 nop
I 5203  23 li   r1, 3
I 427F  24 addi r1, r1, -1
I 907E  25 bnez r1, -2 back to 24
I 7700  26 st   r3, 0(r4)
I 6D00  27 ld   r6, 0(r4)
I D000  28 undefined opcode
I 5E33  29 li   r7, 0x33 never runs
I 5244  30 li   r1, 0x44 never runs
W 1 0005  pc 00
W 2 0003  pc 01
W 3 0008  pc 02
W 4 0003  pc 03
W 5 0001  pc 04
W 6 0009  pc 05
W 7 0007  pc 06
W 0 FFFF  pc 07
W 2 0007  pc 09
W 3 000E  pc 10
W 4 0000  pc 15
W 1 0003  pc 23
W 1 0002  pc 24
W 1 0001  pc 24
W 1 0000  pc 24
W 6 000E  pc 27
E 1

// File: regWriteIf.sv
interface regWriteIf;
    import procPkg::*;

    logic en;
    logic [regAddrW-1:0] addr;
    logic [dataW-1:0] data;
    // PC of the instruction that writes
    logic [dataW-1:0] pc;

    // Write-back side
    modport source (
        output en, addr, data, pc
    );

    // Register file side
    modport sink (
        input en, addr, data, pc
    );

endinterface

// File: stallUnit.sv
module stallUnit (
    input  logic          ifIdValid,
    input  procPkg::ifIdT ifIdData,
    input  logic          idExValid,
    input  procPkg::idExT idExData,
    input  logic          exMemValid,
    input  procPkg::exMemT exMemData,
    output logic          stall
);
    import procPkg::*;

    opcodeT op;
    logic [regAddrW-1:0] rd;
    logic [regAddrW-1:0] rs;
    logic [regAddrW-1:0] rt;
    logic readsRs;
    logic readsRt;
    logic readsRd;

    // Register still waiting for an older write
    function automatic logic pending(input logic [regAddrW-1:0] r);
        return (idExValid && idExData.regWrite && idExData.dest == r) ||
               (exMemValid && exMemData.regWrite && exMemData.dest == r);
    endfunction

    assign op = opcodeT'(ifIdData.instr[15:12]);
    assign rd = ifIdData.instr[11:9];
    assign rs = ifIdData.instr[8:6];
    assign rt = ifIdData.instr[5:3];

    assign readsRt = op inside {opAdd, opSub, opAnd, opXor};
    assign readsRs = readsRt || (op inside {opAddi, opLd, opSt, opBeqz, opBnez});
    assign readsRd = (op == opSt);

    always_comb begin
        stall = ifIdValid && ((readsRs && pending(rs)) ||
                              (readsRt && pending(rt)) ||
                              (readsRd && pending(rd)));
    end

endmodule

// File: tbProc.sv
module tbProc;
    import procPkg::*;

    logic clk = 1'b0;
    logic rstN;
    logic [dataW-1:0] instrAddr;
    logic [dataW-1:0] instrData;
    logic wbEn;
    logic [regAddrW-1:0] wbReg;
    logic [dataW-1:0] wbData;
    logic [dataW-1:0] wbPc;
    logic halted;
    logic err;

    logic [dataW-1:0] rom [256];
    int romWords = 0;
    logic loaded = 1'b0;
    logic traceOk;

    always #10 clk = ~clk;

    // Fetch reads the word in the same cycle
    assign instrData = rom[instrAddr[7:0]];

    proc i_proc (
        .clk(clk), .rstN(rstN), .instrAddr(instrAddr), .instrData(instrData),
        .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData), .wbPc(wbPc),
        .halted(halted), .err(err)
    );

    procChecker wbCheck (
        .clk(clk), .rstN(rstN), .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData),
        .wbPc(wbPc), .halted(halted), .err(err)
    );

    task automatic loadTrace(output logic ok);
        int fd;
        int n;
        int r;
        logic [dataW-1:0] word;
        logic [8*8-1:0] tag;
        logic [8*128-1:0] rest;
        // Unused words decode as halt
        for (int i = 0; i < 256; i++) begin
            rom[i] = {opHalt, 4'h0, i[7:0]};
        end
        fd = $fopen("procTrace.txt", "r");
        ok = (fd != 0);
        if (ok) begin
            tag = '0;
            while ($fscanf(fd, "%s", tag) == 1) begin
                if (tag == "I") begin
                    n = $fscanf(fd, "%h", word);
                    rom[romWords] = word;
                    wbCheck.addInstr(word);
                    romWords++;
                end else if (tag == "W") begin
                    n = $fscanf(fd, "%d %h", r, word);
                    wbCheck.addWrite(r[regAddrW-1:0], word);
                end else if (tag == "E") begin
                    n = $fscanf(fd, "%d", r);
                    wbCheck.setExpectedErr(r != 0);
                end
                // Anything left on the line is a remark
                n = $fgets(rest, fd);
                tag = '0;
            end
            $fclose(fd);
        end
    endtask

    task automatic printCounts();
        $display("Register writes seen %0d, expected %0d, errors %0d",
                 wbCheck.writeCount, wbCheck.expCount, wbCheck.errorCount);
    endtask

    task automatic stopWithFailure(input string reason);
        $display("ERROR at %0t: %s", $time, reason);
        printCounts();
        $display("TEST RESULT: FAIL");
        $finish;
    endtask

    initial begin
        rstN <= 1'b0;
        loadTrace(traceOk);
        if (!traceOk) begin
            stopWithFailure("could not open procTrace.txt");
        end else begin
            loaded = 1'b1;
            repeat (2) @(posedge clk);
            rstN <= 1'b1;
            wait (halted === 1'b1);
            // A few more cycles to catch stray writes
            repeat (4) @(posedge clk);
            wbCheck.checkEnd();
            printCounts();
            if (wbCheck.errorCount == 0) begin
                $display("TEST RESULT: PASS");
            end else begin
                $display("TEST RESULT: FAIL");
            end
            $finish;
        end
    end

    // Scaled to the program length
    initial begin
        wait (loaded);
        repeat (20 * romWords + 100) @(posedge clk);
        stopWithFailure("watchdog expired before the core halted");
    end

endmodule

// File: tinyProc.f
procPkg.sv
regWriteIf.sv
pipeReg.sv
fetchStage.sv
stallUnit.sv
decodeStage.sv
executeStage.sv
memWbStage.sv
proc.sv
procChecker.sv
tbProc.sv
